// File: axi_lite_regs.f
+incdir+include
verilog/axi_lite_pkg.sv
verilog/axi_lite_read.sv
verilog/axi_lite_write.sv
verilog/axi_lite_reg_bank.sv
verilog/axi_lite_regs.sv
sim/axi_lite_regs_properties.sv
sim/axi_lite_regs_tb.sv

// File: include/axi_lite_settings.svh
`ifndef AXI_LITE_SETTINGS_SVH
`define AXI_LITE_SETTINGS_SVH

// byte address, bits 1:0 are ignored by the slave
`define AXI_LITE_ADDR_WIDTH 4

// registers behind the slave, the last one is read-only
`define AXI_LITE_REG_COUNT 4

// identification word returned by the last register
`define AXI_LITE_ID_VALUE 32'h4C52_0100

`endif

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
    --top-module axi_lite_regs_tb --Mdir obj_dir -o axi_lite_regs_sim \
    -f axi_lite_regs.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/axi_lite_regs_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "simulation did not report success"
exit 1

// File: sim/axi_lite_regs_properties.sv
`timescale 1ns/100ps

module axi_lite_regs_properties
    import axi_lite_pkg::*;
(
    input logic   axi_clk,
    input logic   resetn,
    input logic   ar_ready,
    input axi_r_t r,
    input logic   r_valid,
    input logic   r_ready,
    input axi_b_t b,
    input logic   b_valid,
    input logic   b_ready
);

    // read response held while the master stalls
    r_stable: assert property (@(posedge axi_clk) disable iff (!resetn)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)))
        else $error("read response changed before it was accepted");

    b_stable: assert property (@(posedge axi_clk) disable iff (!resetn)
        (b_valid && !b_ready) |=> (b_valid && $stable(b)))
        else $error("write response changed before it was accepted");

    // one read in flight
    ar_blocked: assert property (@(posedge axi_clk) disable iff (!resetn)
        r_valid |-> !ar_ready)
        else $error("arready high while a read response is pending");

endmodule

bind axi_lite_regs axi_lite_regs_properties u_properties (
    .axi_clk  (axi_clk),
    .resetn   (resetn),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready)
);

// File: sim/axi_lite_regs_tb.sv
`timescale 1ns/100ps
`include "axi_lite_settings.svh"

module axi_lite_regs_tb
    import axi_lite_pkg::*;
();

    // about 60 transactions of under 12 cycles each, with margin
    localparam int TIMEOUT_CYCLES = 2000;

    typedef logic [`AXI_LITE_ADDR_WIDTH-1:0] addr_t;

    logic        axi_clk;
    logic        resetn;
    axi_ar_t     ar;
    axi_aw_t     aw;
    axi_w_t      w;
    axi_r_t      r;
    axi_b_t      b;
    logic        ar_valid, ar_ready, r_valid, r_ready;
    logic        aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic [31:0] model [`AXI_LITE_REG_COUNT];    // expected register contents
    logic [31:0] rng_state = 32'h4ee7_5d77;
    int unsigned cycle_count = 0;

    axi_lite_regs dut (.*);

    initial
    begin
        axi_clk = 1'b0;
        forever #2 axi_clk = ~axi_clk;
    end

    always @(posedge axi_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // xorshift32 step
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] apply_strobe(input logic [31:0] old_word,
                                                 input logic [31:0] new_word,
                                                 input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // one read, rvalid must rise exactly one cycle after the ar handshake
    task automatic axi_read(input addr_t addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        ar.addr  = addr;
        ar_valid = 1'b1;
        while (!ar_ready) @(negedge axi_clk);
        @(negedge axi_clk);                 // handshake edge just passed
        ar_valid = 1'b0;
        check_value("ar_ready", 32'(ar_ready), 32'd0);
        check_value("r_valid", 32'(r_valid), 32'd0);
        @(negedge axi_clk);
        check_value("r_valid", 32'(r_valid), 32'd1);
        data = r.data;
        resp = r.resp;
        repeat (hold)
        begin
            @(negedge axi_clk);
            check_value("r_valid", 32'(r_valid), 32'd1);
            check_value("r.data", r.data, data);
        end
        r_ready = 1'b1;
        @(negedge axi_clk);
        r_ready = 1'b0;
        check_value("r_valid", 32'(r_valid), 32'd0);
        check_value("ar_ready", 32'(ar_ready), 32'd1);    // free for the next read
    endtask

    // aw and w run on their own, bvalid one cycle after the later handshake
    task automatic axi_write(input addr_t addr, input logic [31:0] data, input logic [3:0] strb,
                             input int aw_gap, input int w_gap, input int hold,
                             output logic [1:0] resp);
        fork
            begin
                repeat (aw_gap) @(negedge axi_clk);
                aw.addr  = addr;
                aw_valid = 1'b1;
                while (!aw_ready) @(negedge axi_clk);
                @(negedge axi_clk);
                aw_valid = 1'b0;
                check_value("aw_ready", 32'(aw_ready), 32'd0);
            end
            begin
                repeat (w_gap) @(negedge axi_clk);
                w       = '{data: data, strb: strb};
                w_valid = 1'b1;
                while (!w_ready) @(negedge axi_clk);
                @(negedge axi_clk);
                w_valid = 1'b0;
                check_value("w_ready", 32'(w_ready), 32'd0);
            end
        join
        check_value("b_valid", 32'(b_valid), 32'd0);
        @(negedge axi_clk);
        check_value("b_valid", 32'(b_valid), 32'd1);
        check_value("aw_ready", 32'(aw_ready), 32'd0);
        check_value("w_ready", 32'(w_ready), 32'd0);
        resp = b.resp;
        repeat (hold)
        begin
            @(negedge axi_clk);
            check_value("b_valid", 32'(b_valid), 32'd1);
            check_value("b.resp", 32'(b.resp), 32'(resp));
            check_value("aw_ready", 32'(aw_ready), 32'd0);    // held-off bready blocks writes
            check_value("w_ready", 32'(w_ready), 32'd0);
        end
        b_ready = 1'b1;
        @(negedge axi_clk);
        b_ready = 1'b0;
        check_value("b_valid", 32'(b_valid), 32'd0);
        check_value("aw_ready", 32'(aw_ready), 32'd1);
        check_value("w_ready", 32'(w_ready), 32'd1);
    endtask

    task automatic write_and_check(input addr_t addr, input logic [31:0] data,
                                   input logic [3:0] strb, input int aw_gap,
                                   input int w_gap, input int hold);
        logic [1:0] resp;
        logic [1:0] index;
        index = addr[`AXI_LITE_ADDR_WIDTH-1:2];
        axi_write(addr, data, strb, aw_gap, w_gap, hold, resp);
        if (index == 2'(`AXI_LITE_REG_COUNT - 1))
            check_value("b.resp", 32'(resp), 32'(SLVERR));     // id word is read-only
        else
        begin
            check_value("b.resp", 32'(resp), 32'(OKAY));
            model[index] = apply_strobe(model[index], data, strb);
        end
    endtask

    task automatic read_and_check(input addr_t addr, input int hold);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, hold, data, resp);
        check_value("r.data", data, model[addr[`AXI_LITE_ADDR_WIDTH-1:2]]);
        check_value("r.resp", 32'(resp), 32'(OKAY));
    endtask

    // outputs quiet in reset, readies up from the first edge after it
    task automatic test_reset_outputs();
        check_value("ar_ready", 32'(ar_ready), 32'd0);
        check_value("aw_ready", 32'(aw_ready), 32'd0);
        check_value("w_ready", 32'(w_ready), 32'd0);
        check_value("r_valid", 32'(r_valid), 32'd0);
        check_value("b_valid", 32'(b_valid), 32'd0);
        resetn = 1'b1;
        @(negedge axi_clk);
        check_value("ar_ready", 32'(ar_ready), 32'd1);
        check_value("aw_ready", 32'(aw_ready), 32'd1);
        check_value("w_ready", 32'(w_ready), 32'd1);
    endtask

    task automatic test_reset_values();
        for (int i = 0; i < `AXI_LITE_REG_COUNT; i++)
            read_and_check(addr_t'(4 * i), 0);
    endtask

    task automatic test_full_writes();
        for (int i = 0; i < `AXI_LITE_REG_COUNT - 1; i++)
        begin
            write_and_check(addr_t'(4 * i), next_random(), 4'hf, 0, 0, 0);
            read_and_check(addr_t'(4 * i), 0);
        end
    endtask

    task automatic test_partial_writes();
        logic [31:0] pick;
        logic [1:0]  index;
        for (int n = 0; n < 20; n++)
        begin
            pick  = next_random();
            index = 2'(pick % 3);
            // low address bits are don't-care
            write_and_check({index, pick[5:4]}, next_random(), pick[11:8], 0, 0, 0);
            read_and_check({index, pick[7:6]}, 0);
        end
    endtask

    task automatic test_read_only();
        write_and_check(addr_t'(12), next_random(), 4'hf, 0, 0, 0);
        for (int i = 0; i < `AXI_LITE_REG_COUNT; i++)
            read_and_check(addr_t'(4 * i), 0);
    endtask

    task automatic test_orderings();
        write_and_check(addr_t'(0), next_random(), 4'hf, 0, 3, 4);    // aw first
        read_and_check(addr_t'(0), 3);
        write_and_check(addr_t'(4), next_random(), 4'h5, 3, 0, 2);    // w first
        read_and_check(addr_t'(4), 5);
        write_and_check(addr_t'(8), next_random(), 4'ha, 2, 2, 0);    // together after a gap
        read_and_check(addr_t'(8), 1);
        write_and_check(addr_t'(12), next_random(), 4'hf, 2, 0, 3);
        read_and_check(addr_t'(12), 2);
    endtask

    initial
    begin
        resetn   = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        for (int i = 0; i < `AXI_LITE_REG_COUNT; i++)
            model[i] = (i == `AXI_LITE_REG_COUNT - 1) ? `AXI_LITE_ID_VALUE : 32'd0;
        repeat (3) @(negedge axi_clk);
        test_reset_outputs();
        test_reset_values();
        test_full_writes();
        test_partial_writes();
        test_read_only();
        test_orderings();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verilog/axi_lite_pkg.sv
`include "axi_lite_settings.svh"

package axi_lite_pkg;

    // only the two codes this slave can return
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // read address channel payload
    typedef struct packed {
        logic [`AXI_LITE_ADDR_WIDTH-1:0] addr;
    } axi_ar_t;

    // write address channel payload
    typedef struct packed {
        logic [`AXI_LITE_ADDR_WIDTH-1:0] addr;
    } axi_aw_t;

    // write data channel payload
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;     // one bit per byte lane
    } axi_w_t;

    // read data channel payload
    typedef struct packed {
        logic [31:0] data;
        axi_resp_t   resp;
    } axi_r_t;

    // write response channel payload
    typedef struct packed {
        axi_resp_t resp;
    } axi_b_t;

    // request from the write block to the bank, valid with wr_strobe
    typedef struct packed {
        logic [1:0]  index;    // word index, address bits 3:2
        logic [31:0] data;
        logic [3:0]  strb;
    } reg_wr_t;

endpackage

// File: verilog/axi_lite_read.sv
`timescale 1ns/100ps
`include "axi_lite_settings.svh"

module axi_lite_read
    import axi_lite_pkg::*;
(
    input  logic        axi_clk,
    input  logic        resetn,

    // read address channel
    input  axi_ar_t     ar,
    input  logic        ar_valid,
    output logic        ar_ready,

    // read data channel
    output axi_r_t      r,
    output logic        r_valid,
    input  logic        r_ready,

    // register bank side
    output logic [1:0]  rd_index,
    input  logic [31:0] rd_data
);

    logic    addr_done;    // address taken, bank word fetched next edge
    axi_ar_t addr_latch;
    logic    ar_fire;
    logic    r_fire;

    assign ar_fire = ar_valid & ar_ready;
    assign r_fire  = r_valid & r_ready;

    // word index from the latched byte address
    assign rd_index = addr_latch.addr[`AXI_LITE_ADDR_WIDTH-1:2];

    // address handshake
    // ready stays low from the handshake until the read data is taken
    always_ff @(posedge axi_clk)
    begin
        if (!resetn)
            ar_ready <= 1'b0;
        else if (ar_fire)
            ar_ready <= 1'b0;
        else if (!addr_done && (!r_valid || r_fire))
            ar_ready <= 1'b1;
    end

    // single cycle flag after the address handshake
    always_ff @(posedge axi_clk)
    begin
        if (!resetn)
            addr_done <= 1'b0;
        else
            addr_done <= ar_fire;
    end

    always_ff @(posedge axi_clk)
    begin
        if (ar_fire)
            addr_latch <= ar;
    end

    // read response valid, held until the master accepts it
    always_ff @(posedge axi_clk)
    begin
        if (!resetn)
            r_valid <= 1'b0;
        else if (addr_done)
            r_valid <= 1'b1;
        else if (r_fire)
            r_valid <= 1'b0;
    end

    // data captured from the bank, reads never fail
    always_ff @(posedge axi_clk)
    begin
        if (addr_done)
            r <= '{data: rd_data, resp: OKAY};
    end

endmodule

// File: verilog/axi_lite_reg_bank.sv
`timescale 1ns/100ps
`include "axi_lite_settings.svh"

module axi_lite_reg_bank
    import axi_lite_pkg::*;
(
    input  logic        axi_clk,
    input  logic        resetn,

    // write request, valid for one cycle with the strobe
    input  reg_wr_t     wr,
    input  logic        wr_strobe,
    output logic        wr_err,

    // combinational read port
    input  logic [1:0]  rd_index,
    output logic [31:0] rd_data
);

    // writable registers sit below the id word
    localparam int         RW_COUNT = `AXI_LITE_REG_COUNT - 1;
    localparam logic [1:0] ID_INDEX = 2'(`AXI_LITE_REG_COUNT - 1);

    logic [31:0] regs [RW_COUNT];

    // replace only the strobed byte lanes
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] result;
        result = old_word;
        for (int k = 0; k < 4; k++)
        begin
            if (strb[k])
                result[8*k +: 8] = new_word[8*k +: 8];
        end
        return result;
    endfunction

    // id word is read-only
    assign wr_err = (wr.index == ID_INDEX);

    always_ff @(posedge axi_clk)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < RW_COUNT; i++)
                regs[i] <= 32'd0;
        end
        else if (wr_strobe && !wr_err)
        begin
            for (int i = 0; i < RW_COUNT; i++)
            begin
                if (wr.index == 2'(i))
                    regs[i] <= merge_bytes(regs[i], wr.data, wr.strb);
            end
        end
    end

    // read mux, falls through to the id word
    always_comb
    begin
        rd_data = `AXI_LITE_ID_VALUE;
        for (int i = 0; i < RW_COUNT; i++)
        begin
            if (rd_index == 2'(i))
                rd_data = regs[i];
        end
    end

endmodule

// File: verilog/axi_lite_regs.sv
`timescale 1ns/100ps

module axi_lite_regs
    import axi_lite_pkg::*;
(
    input  logic    axi_clk,
    input  logic    resetn,

    // read channels
    input  axi_ar_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output axi_r_t  r,
    output logic    r_valid,
    input  logic    r_ready,

    // write channels
    input  axi_aw_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_w_t  w,
    input  logic    w_valid,
    output logic    w_ready,
    output axi_b_t  b,
    output logic    b_valid,
    input  logic    b_ready
);

    logic [1:0]  rd_index;
    logic [31:0] rd_data;
    reg_wr_t     wr;
    logic        wr_strobe;
    logic        wr_err;     // write hit the read-only word

    axi_lite_read u_read (
        .axi_clk  (axi_clk),
        .resetn   (resetn),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

    axi_lite_write u_write (
        .axi_clk   (axi_clk),
        .resetn    (resetn),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .wr        (wr),
        .wr_strobe (wr_strobe),
        .wr_err    (wr_err)
    );

    axi_lite_reg_bank u_bank (
        .axi_clk   (axi_clk),
        .resetn    (resetn),
        .wr        (wr),
        .wr_strobe (wr_strobe),
        .wr_err    (wr_err),
        .rd_index  (rd_index),
        .rd_data   (rd_data)
    );

endmodule

// File: verilog/axi_lite_write.sv
`timescale 1ns/100ps
`include "axi_lite_settings.svh"

module axi_lite_write
    import axi_lite_pkg::*;
(
    input  logic    axi_clk,
    input  logic    resetn,

    // write address channel
    input  axi_aw_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,

    // write data channel
    input  axi_w_t  w,
    input  logic    w_valid,
    output logic    w_ready,

    // write response channel
    output axi_b_t  b,
    output logic    b_valid,
    input  logic    b_ready,

    // register bank side
    output reg_wr_t wr,
    output logic    wr_strobe,
    input  logic    wr_err
);

    logic    aw_done;      // address phase complete
    logic    w_done;       // data phase complete
    axi_aw_t aw_latch;
    axi_w_t  w_latch;
    logic    aw_fire;
    logic    w_fire;
    logic    b_fire;

    assign aw_fire = aw_valid & aw_ready;
    assign w_fire  = w_valid & w_ready;
    assign b_fire  = b_valid & b_ready;

    // both phases in, one cycle pulse since the flags clear on the next edge
    assign wr_strobe = aw_done & w_done;

    assign wr = '{index: aw_latch.addr[`AXI_LITE_ADDR_WIDTH-1:2],
                  data:  w_latch.data,
                  strb:  w_latch.strb};

    // address ready, low from its handshake until the response is taken
    always_ff @(posedge axi_clk)
    begin
        if (!resetn)
            aw_ready <= 1'b0;
        else if (aw_fire)
            aw_ready <= 1'b0;
        else if (!aw_done && (!b_valid || b_fire))
            aw_ready <= 1'b1;
    end

    // data ready, same rule on its own flag
    always_ff @(posedge axi_clk)
    begin
        if (!resetn)
            w_ready <= 1'b0;
        else if (w_fire)
            w_ready <= 1'b0;
        else if (!w_done && (!b_valid || b_fire))
            w_ready <= 1'b1;
    end

    // handshakes may complete in either order
    always_ff @(posedge axi_clk)
    begin
        if (!resetn || wr_strobe)
        begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end
        else
        begin
            if (aw_fire)
                aw_done <= 1'b1;
            if (w_fire)
                w_done <= 1'b1;
        end
    end

    always_ff @(posedge axi_clk)
    begin
        if (aw_fire)
            aw_latch <= aw;
        if (w_fire)
            w_latch <= w;
    end

    // response raised with the register update
    always_ff @(posedge axi_clk)
    begin
        if (!resetn)
            b_valid <= 1'b0;
        else if (wr_strobe)
            b_valid <= 1'b1;
        else if (b_fire)
            b_valid <= 1'b0;
    end

    always_ff @(posedge axi_clk)
    begin
        if (wr_strobe)
            b.resp <= wr_err ? SLVERR : OKAY;   // bank refused the write
    end

endmodule
